//--- common/sifhPkg.sv
package sifhPkg;

    // time code from the TDC
    localparam int TDC_WIDTH = 10;

    // bin index is the upper part of a code, 32 bins
    localparam int BIN_BITS = 5;

    // bin counts saturate at all ones
    localparam int COUNT_WIDTH = 4;

    typedef logic [TDC_WIDTH-1:0] tdcCode;

    typedef logic [BIN_BITS-1:0] binIndex;

    typedef logic [COUNT_WIDTH-1:0] binCount;

    // sequencer states
    // INIT clears the RAM once after reset
    // ACCUM takes codes, DRAIN lets the last increment land
    // SCAN reads and clears all bins, REPORT waits for the peak
    typedef enum logic [2:0] {
        INIT,
        ACCUM,
        DRAIN,
        SCAN,
        REPORT
    } fsmState;

endpackage

//--- histogram/histogramRam.sv
module histogramRam (
    input  logic             clk,
    // read port, registered
    input  sifhPkg::binIndex raddr,
    input  logic             rEnable,
    output sifhPkg::binCount counts,
    // write port
    input  sifhPkg::binIndex waddr,
    input  logic             wEnable,
    input  sifhPkg::binCount newCounts
);

    localparam int depth = 2 ** sifhPkg::BIN_BITS;

    // one count per bin
    sifhPkg::binCount mem [depth];

    // read returns old data on a same-address write
    // binAccumulator forwards around that case
    always_ff @(posedge clk) begin
        if (rEnable) begin
            counts <= mem[raddr];
        end
    end

    always_ff @(posedge clk) begin
        if (wEnable) begin
            mem[waddr] <= newCounts;
        end
    end

endmodule

//--- histogram/binAccumulator.sv
module binAccumulator (
    input  logic             clk,
    input  logic             reset,
    // increment request
    input  logic             sampleValid,
    input  sifhPkg::binIndex sampleBin,
    // clearing scan request
    input  logic             scanValid,
    input  sifhPkg::binIndex scanBin,
    input  logic             scanLast,
    // RAM read port
    output sifhPkg::binIndex raddr,
    output logic             rEnable,
    input  sifhPkg::binCount counts,
    // RAM write port
    output sifhPkg::binIndex waddr,
    output logic             wEnable,
    output sifhPkg::binCount newCounts,
    // scanned counts towards peakSearch
    output logic             scanCountValid,
    output sifhPkg::binCount scanCount,
    output sifhPkg::binIndex scanCountBin,
    output logic             scanCountLast
);

    // pending stage holds one operation in flight
    logic             pendValid;
    logic             pendScan;
    logic             pendLast;
    logic             pendFwd;
    sifhPkg::binIndex pendBin;

    // copy of the previous write for forwarding
    sifhPkg::binCount lastWrite;

    // count before this operation
    sifhPkg::binCount oldCount;
    sifhPkg::binCount incCount;

    // shared read port since requests never overlap
    assign raddr   = sampleValid ? sampleBin : scanBin;
    assign rEnable = sampleValid | scanValid;

    always_ff @(posedge clk) begin
        if (reset) begin
            pendValid <= 1'b0;
        end else begin
            pendValid <= sampleValid | scanValid;
        end
    end

    always_ff @(posedge clk) begin
        pendScan  <= scanValid;
        pendLast  <= scanValid & scanLast;
        pendBin   <= raddr;
        // back-to-back hit makes the RAM read stale
        pendFwd   <= pendValid && (pendBin == raddr);
        lastWrite <= newCounts;
    end

    assign oldCount = pendFwd ? lastWrite : counts;

    // saturating increment
    assign incCount = (oldCount == '1) ? oldCount : oldCount + sifhPkg::binCount'(1);

    // write back in the stage after the read
    assign waddr     = pendBin;
    assign wEnable   = pendValid;
    // a scan leaves the bin cleared
    assign newCounts = pendScan ? '0 : incCount;

    assign scanCountValid = pendValid & pendScan;
    assign scanCount      = oldCount;
    assign scanCountBin   = pendBin;
    assign scanCountLast  = pendValid & pendScan & pendLast;

    // sequencer must keep the two request kinds apart
    sampleScanExclusive: assert property (
        @(posedge clk) disable iff (reset)
        !(sampleValid && scanValid)
    );

    // the last scan count always belongs to the top bin
    lastIsTopBin: assert property (
        @(posedge clk) disable iff (reset)
        scanCountLast |-> (scanCountBin == '1)
    );

endmodule

//--- histogram/peakSearch.sv
module peakSearch (
    input  logic             clk,
    input  logic             reset,
    input  logic             scanCountValid,
    input  sifhPkg::binCount scanCount,
    input  sifhPkg::binIndex scanCountBin,
    input  logic             scanCountLast,
    output logic             peakValid,
    output sifhPkg::binIndex peakBin,
    output sifhPkg::binCount peakCount
);

    // running maximum over the scan
    sifhPkg::binCount maxCount;
    sifhPkg::binIndex maxBin;

    // candidate with the current count folded in
    logic             take;
    sifhPkg::binCount candCount;
    sifhPkg::binIndex candBin;

    // bin 0 starts a new scan
    // strictly greater keeps the lowest bin on a tie
    assign take      = (scanCountBin == '0) || (scanCount > maxCount);
    assign candCount = take ? scanCount : maxCount;
    assign candBin   = take ? scanCountBin : maxBin;

    always_ff @(posedge clk) begin
        if (scanCountValid) begin
            maxCount <= candCount;
            maxBin   <= candBin;
        end
    end

    // result registered on the last count
    always_ff @(posedge clk) begin
        if (scanCountValid && scanCountLast) begin
            peakBin   <= candBin;
            peakCount <= candCount;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            peakValid <= 1'b0;
        end else begin
            peakValid <= scanCountValid & scanCountLast;
        end
    end

    // a report needs the first count of its 32-bin scan
    reportAfterScan: assert property (
        @(posedge clk) disable iff (reset)
        peakValid |-> $past(scanCountValid, 32)
    );

endmodule

//--- histogram/sifhFsm.sv
module sifhFsm #(
    parameter int pixelsPerFrame  = 4,
    parameter int samplesPerPixel = 20,
    localparam int pixelBits  = (pixelsPerFrame > 1) ? $clog2(pixelsPerFrame) : 1,
    localparam int sampleBits = (samplesPerPixel > 1) ? $clog2(samplesPerPixel) : 1
) (
    input  logic                 clk,
    input  logic                 reset,
    // code source
    input  logic                 wrEn,
    input  sifhPkg::tdcCode      data,
    output logic                 busy,
    // increment requests
    output logic                 sampleValid,
    output sifhPkg::binIndex     sampleBin,
    // clearing scan requests
    output logic                 scanValid,
    output sifhPkg::binIndex     scanBin,
    output logic                 scanLast,
    // result side
    input  logic                 peakValid,
    output logic [pixelBits-1:0] peakPixel,
    output logic                 frameDone
);

    sifhPkg::fsmState state;

    // msb marks the extra INIT cycle after the last clear read
    logic [sifhPkg::BIN_BITS:0] sweepCount;

    logic [sampleBits-1:0] sampleCount;
    logic [pixelBits-1:0]  pixelCount;

    logic sweepReading;
    logic lastSample;
    logic lastPixel;

    // all 32 addresses issued while msb is low
    assign sweepReading = ~sweepCount[sifhPkg::BIN_BITS];

    assign lastSample = (sampleCount == sampleBits'(samplesPerPixel - 1));
    assign lastPixel  = (pixelCount == pixelBits'(pixelsPerFrame - 1));

    // codes are only taken in ACCUM
    assign busy        = (state != sifhPkg::ACCUM);
    assign sampleValid = wrEn && (state == sifhPkg::ACCUM);
    // bin is the upper part of the code
    assign sampleBin   = data[sifhPkg::TDC_WIDTH-1 -: sifhPkg::BIN_BITS];

    // INIT and SCAN share the sweep
    assign scanValid = ((state == sifhPkg::INIT) && sweepReading) || (state == sifhPkg::SCAN);
    assign scanBin   = sweepCount[sifhPkg::BIN_BITS-1:0];
    // INIT never flags last, so its counts go nowhere
    assign scanLast  = (state == sifhPkg::SCAN) && (scanBin == '1);

    assign peakPixel = pixelCount;
    assign frameDone = peakValid && (state == sifhPkg::REPORT) && lastPixel;

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= sifhPkg::INIT;
            sweepCount  <= '0;
            sampleCount <= '0;
            pixelCount  <= '0;
        end else begin
            unique case (state)
                sifhPkg::INIT: begin
                    sweepCount <= sweepCount + 1'b1;
                    // one spare cycle for the last clear write
                    if (!sweepReading) begin
                        sweepCount <= '0;
                        state      <= sifhPkg::ACCUM;
                    end
                end
                sifhPkg::ACCUM: begin
                    if (sampleValid) begin
                        sampleCount <= sampleCount + 1'b1;
                        if (lastSample) begin
                            sampleCount <= '0;
                            state       <= sifhPkg::DRAIN;
                        end
                    end
                end
                sifhPkg::DRAIN: begin
                    // last increment writes here
                    state <= sifhPkg::SCAN;
                end
                sifhPkg::SCAN: begin
                    sweepCount <= sweepCount + 1'b1;
                    if (scanLast) begin
                        sweepCount <= '0;
                        state      <= sifhPkg::REPORT;
                    end
                end
                sifhPkg::REPORT: begin
                    if (peakValid) begin
                        state <= sifhPkg::ACCUM;
                        // wraps at the end of the frame
                        if (lastPixel) begin
                            pixelCount <= '0;
                        end else begin
                            pixelCount <= pixelCount + 1'b1;
                        end
                    end
                end
                default: begin
                    state <= sifhPkg::INIT;
                end
            endcase
        end
    end

    // no back-pressure, the source has to watch busy
    noWriteWhileBusy: assert property (
        @(posedge clk) disable iff (reset)
        busy |-> !wrEn
    );

    // report state always ends with a result
    reportEnds: assert property (
        @(posedge clk) disable iff (reset)
        $rose(state == sifhPkg::REPORT) |-> ##1 peakValid
    );

endmodule

//--- verilog/sifhTop.sv
module sifhTop #(
    parameter int pixelsPerFrame  = 4,
    parameter int samplesPerPixel = 20,
    localparam int pixelBits = (pixelsPerFrame > 1) ? $clog2(pixelsPerFrame) : 1
) (
    input  logic                 clk,
    input  logic                 reset,
    // code stream
    input  logic                 wrEn,
    input  sifhPkg::tdcCode      data,
    output logic                 busy,
    // peak stream, one entry per pixel
    output logic                 peakValid,
    output logic [pixelBits-1:0] peakPixel,
    output sifhPkg::tdcCode      peakCode,
    output sifhPkg::binCount     peakCount,
    output logic                 frameDone
);

    // sequencer to accumulator
    logic             sampleValid;
    sifhPkg::binIndex sampleBin;
    logic             scanValid;
    sifhPkg::binIndex scanBin;
    logic             scanLast;

    // accumulator to RAM
    sifhPkg::binIndex raddr;
    logic             rEnable;
    sifhPkg::binCount counts;
    sifhPkg::binIndex waddr;
    logic             wEnable;
    sifhPkg::binCount newCounts;

    // accumulator to peak search
    logic             scanCountValid;
    sifhPkg::binCount scanCount;
    sifhPkg::binIndex scanCountBin;
    logic             scanCountLast;

    sifhPkg::binIndex peakBin;

    sifhFsm #(
        .pixelsPerFrame (pixelsPerFrame),
        .samplesPerPixel(samplesPerPixel)
    ) fsm (
        .clk        (clk),
        .reset      (reset),
        .wrEn       (wrEn),
        .data       (data),
        .busy       (busy),
        .sampleValid(sampleValid),
        .sampleBin  (sampleBin),
        .scanValid  (scanValid),
        .scanBin    (scanBin),
        .scanLast   (scanLast),
        .peakValid  (peakValid),
        .peakPixel  (peakPixel),
        .frameDone  (frameDone)
    );

    binAccumulator accum (
        .clk           (clk),
        .reset         (reset),
        .sampleValid   (sampleValid),
        .sampleBin     (sampleBin),
        .scanValid     (scanValid),
        .scanBin       (scanBin),
        .scanLast      (scanLast),
        .raddr         (raddr),
        .rEnable       (rEnable),
        .counts        (counts),
        .waddr         (waddr),
        .wEnable       (wEnable),
        .newCounts     (newCounts),
        .scanCountValid(scanCountValid),
        .scanCount     (scanCount),
        .scanCountBin  (scanCountBin),
        .scanCountLast (scanCountLast)
    );

    histogramRam ram (
        .clk      (clk),
        .raddr    (raddr),
        .rEnable  (rEnable),
        .counts   (counts),
        .waddr    (waddr),
        .wEnable  (wEnable),
        .newCounts(newCounts)
    );

    peakSearch peak (
        .clk           (clk),
        .reset         (reset),
        .scanCountValid(scanCountValid),
        .scanCount     (scanCount),
        .scanCountBin  (scanCountBin),
        .scanCountLast (scanCountLast),
        .peakValid     (peakValid),
        .peakBin       (peakBin),
        .peakCount     (peakCount)
    );

    // bin centre, low part is 1 followed by zeros
    assign peakCode = {peakBin, 1'b1, {(sifhPkg::TDC_WIDTH - sifhPkg::BIN_BITS - 1){1'b0}}};

endmodule

//--- bench/clockGen.sv
module clockGen #(
    parameter int period = 40
) (
    output logic clk
);

    // half period per phase
    localparam int halfPeriod = period / 2;

    // starts low so the first rising edge is at halfPeriod
    initial begin
        clk = 1'b0;
        forever begin
            #(halfPeriod) clk = ~clk;
        end
    end

endmodule

//--- bench/sifhTb.sv
module sifhTb;

    localparam int numPixels = 4;
    localparam int numCodes  = 20;
    // 32 clear reads and one spare edge until busy falls
    localparam int initCycles = 33;
    // edges from the last accepted code until peakValid is seen
    localparam int peakLatency = 34;
    // upper bound for any wait loop
    localparam int waitLimit = 200;
    // inputs change this long after the rising edge
    localparam int driveDelay = 2;

    logic             clk;
    logic             reset;
    logic             wrEn;
    sifhPkg::tdcCode  data;
    logic             busy;
    logic             peakValid;
    logic [1:0]       peakPixel;
    sifhPkg::tdcCode  peakCode;
    sifhPkg::binCount peakCount;
    logic             frameDone;

    // pixel 0 puts 12 codes in bin 10 (320..351) and spreads the rest thin
    // pixel 1 sends runs of identical codes without gaps
    // pixel 2 sends 18 codes to bin 28 and overflows its count
    // pixel 3 sends 8 codes each to bins 7 and 20 and none to bin 28
    sifhPkg::tdcCode codeTable [numPixels][numCodes] = '{
        '{10'd320, 10'd5,   10'd322, 10'd325, 10'd70,  10'd328, 10'd331, 10'd334,
          10'd200, 10'd337, 10'd340, 10'd71,  10'd343, 10'd450, 10'd346, 10'd349,
          10'd600, 10'd351, 10'd700, 10'd1020},
        '{10'd100, 10'd100, 10'd100, 10'd100, 10'd100, 10'd100, 10'd100, 10'd100,
          10'd100, 10'd810, 10'd810, 10'd810, 10'd810, 10'd810, 10'd810, 10'd500,
          10'd500, 10'd500, 10'd500, 10'd500},
        '{10'd40,  10'd896, 10'd897, 10'd898, 10'd899, 10'd900, 10'd901, 10'd902,
          10'd903, 10'd50,  10'd904, 10'd905, 10'd906, 10'd907, 10'd908, 10'd909,
          10'd910, 10'd911, 10'd912, 10'd913},
        '{10'd640, 10'd224, 10'd644, 10'd228, 10'd5,   10'd648, 10'd232, 10'd652,
          10'd236, 10'd330, 10'd656, 10'd240, 10'd660, 10'd244, 10'd400, 10'd664,
          10'd248, 10'd668, 10'd252, 10'd1000}
    };

    // bin centre is bin * 32 + 16
    sifhPkg::tdcCode  expCode  [numPixels] = '{10'd336, 10'd112, 10'd912, 10'd240};
    // bin 28 saturates at 15
    // bin 7 wins the tie with bin 20
    sifhPkg::binCount expCount [numPixels] = '{4'd12, 4'd9, 4'd15, 4'd8};
    // pixel 1 runs back to back
    logic             useGaps  [numPixels] = '{1'b1, 1'b0, 1'b1, 1'b1};

    int gap;
    int cycles;

    clockGen #(
        .period(40)
    ) clockSource (
        .clk(clk)
    );

    sifhTop dut (
        .clk      (clk),
        .reset    (reset),
        .wrEn     (wrEn),
        .data     (data),
        .busy     (busy),
        .peakValid(peakValid),
        .peakPixel(peakPixel),
        .peakCode (peakCode),
        .peakCount(peakCount),
        .frameDone(frameDone)
    );

    task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
        if (actual !== expected) begin
            $display("ERROR at time %0t: %s, got %0d expected %0d",
                     $time, what, actual, expected);
            $display("*** TEST FAILED ***");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    task automatic reportTimeout(input string what);
        $display("timeout: %s did not happen within %0d cycles", what, waitLimit);
        $display("*** TEST FAILED ***");
        $fatal(1, "wait limit reached");
    endtask

    // step to just after the next rising edge
    task automatic nextCycle();
        @(posedge clk);
        #(driveDelay);
    endtask

    task automatic idleCycles(input int n);
        wrEn = 1'b0;
        repeat (n) begin
            nextCycle();
        end
    endtask

    // one code accepted on the next edge
    task automatic sendCode(input sifhPkg::tdcCode code);
        wrEn = 1'b1;
        data = code;
        nextCycle();
        wrEn = 1'b0;
    endtask

    task automatic waitBusyLow(output int count);
        count = 0;
        while (busy && count < waitLimit) begin
            nextCycle();
            count++;
        end
        if (busy) begin
            reportTimeout("busy falling");
        end
    endtask

    task automatic waitPeak(output int count);
        count = 0;
        while (!peakValid && count < waitLimit) begin
            nextCycle();
            count++;
        end
        if (!peakValid) begin
            reportTimeout("peakValid");
        end
    endtask

    initial begin
        reset = 1'b1;
        wrEn  = 1'b0;
        data  = '0;
        void'($urandom(32'hc323_25bc));

        // result strobes stay low while reset is held
        for (int i = 0; i < 8; i++) begin
            nextCycle();
            checkValue(peakValid, 0, "peakValid during reset");
            checkValue(frameDone, 0, "frameDone during reset");
        end
        reset = 1'b0;

        // clear sweep of all bins
        waitBusyLow(cycles);
        checkValue(cycles, initCycles, "INIT sweep length");
        checkValue(peakValid, 0, "peakValid after INIT");

        for (int p = 0; p < numPixels; p++) begin
            waitBusyLow(cycles);
            // busy falls one edge after the peakValid pulse
            checkValue(cycles, (p == 0) ? 0 : 1, "busy low at pixel start");
            // previous report was a single pulse
            checkValue(peakValid, 0, "peakValid at pixel start");
            checkValue(frameDone, 0, "frameDone at pixel start");

            for (int c = 0; c < numCodes; c++) begin
                if (c != 0 && useGaps[p]) begin
                    gap = $urandom_range(3, 0);
                    idleCycles(gap);
                end
                sendCode(codeTable[p][c]);
            end

            // DRAIN right after the last code
            checkValue(busy, 1, "busy after last code");

            waitPeak(cycles);
            checkValue(cycles, peakLatency, "peak latency");
            checkValue(peakPixel, p, "peakPixel");
            checkValue(peakCode, expCode[p], "peakCode");
            checkValue(peakCount, expCount[p], "peakCount");
            // only the last pixel closes the frame
            checkValue(frameDone, (p == numPixels - 1) ? 1 : 0, "frameDone");
        end

        // back to idle for the next frame
        nextCycle();
        checkValue(peakValid, 0, "peakValid after frame");
        checkValue(frameDone, 0, "frameDone after frame");
        checkValue(busy, 0, "busy after frame");
        checkValue(peakPixel, 0, "peakPixel wrap");

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

//--- sim.f
common/sifhPkg.sv
histogram/histogramRam.sv
histogram/binAccumulator.sv
histogram/peakSearch.sv
histogram/sifhFsm.sv
verilog/sifhTop.sv
bench/clockGen.sv
bench/sifhTb.sv

//--- runSim.sh
#!/bin/sh
# build the testbench with Verilator and run it
# the exit status is non-zero when the run ends in $fatal
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module sifhTb -o simv \
    && ./obj_dir/simv \
    || exit 1
